// ==== all.f ====
common/camera_cfg_pkg.sv
source/camera_cfg_rom.sv
source/camera_cfg_sequencer.sv
sccb_master/sccb_master.sv
source/camera_cfg_top.sv
testbench/clock_gen.sv
testbench/camera_cfg_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module camera_cfg_tb \
    -f all.f -o camera_cfg_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/camera_cfg_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0

// ==== testbench/camera_cfg_tb.sv ====
`timescale 1ns/1ps

module camera_cfg_tb;

    localparam int unsigned frame_cycles   = 29 * 4 * camera_cfg_pkg::sccb_quarter_cycles;
    localparam int unsigned run_cycles     = 4 * frame_cycles + camera_cfg_pkg::delay_cycles;
    localparam int unsigned timeout_cycles = 3 * 2 * run_cycles;  // Two runs plus margin

    logic        clk;
    logic        reset_n;
    logic        config_start;
    logic        config_done;
    logic        sioc;
    logic        siod;
    logic        sioc_q;
    logic        siod_q;
    logic        config_done_q;
    logic        start_cond;
    logic        stop_cond;
    logic        in_frame;
    logic        frame_end;  // One cycle after each stop
    logic        seen_start;
    logic [27:0] frame_bits;
    logic [26:0] frame_word;
    int unsigned bit_count;
    int unsigned frame_len;
    int unsigned frame_idx;
    int unsigned run_frames;
    int unsigned gap_cnt;
    int unsigned cycle_cnt = 0;

    clock_gen clock_gen_inst (
        .clk     (clk),
        .reset_n (reset_n)
    );

    camera_cfg_top camera_cfg_top_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .config_start (config_start),
        .config_done  (config_done),
        .sioc         (sioc),
        .siod         (siod)
    );

    // Register writes expected on the bus, in table order
    function automatic logic [15:0] table_write(input int unsigned idx);
        case (idx)
            0: return 16'h1280;
            1: return 16'h1204;
            2: return 16'h1101;
            3: return 16'h40D0;
            default: return 16'h0000;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on a failed check");
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(20, 0)) @(posedge clk);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        config_start <= 1'b1;
        @(posedge clk);
        config_start <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // SCCB bus monitor
    //////////////////////////////////////////////////
    assign start_cond = sioc_q && sioc && siod_q && !siod;
    assign stop_cond  = sioc_q && sioc && !siod_q && siod;

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            {sioc_q, siod_q, config_done_q} <= 3'b110;
            {in_frame, frame_end, seen_start} <= 3'b000;
            run_frames <= 0;
            gap_cnt    <= 0;
        end else begin
            sioc_q        <= sioc;
            siod_q        <= siod;
            config_done_q <= config_done;
            frame_end     <= 1'b0;
            gap_cnt       <= gap_cnt + 1;
            seen_start    <= seen_start || config_start;
            if (config_done_q && !config_done) begin
                run_frames <= 0;  // New run accepted
            end
            if (start_cond) begin
                in_frame  <= 1'b1;
                bit_count <= 0;
            end else if (stop_cond) begin
                // Stop phase adds one sioc rise after the 27 data bits
                in_frame   <= 1'b0;
                frame_end  <= 1'b1;
                frame_word <= frame_bits[27:1];
                frame_len  <= bit_count - 1;
                frame_idx  <= run_frames;
                run_frames <= run_frames + 1;
                gap_cnt    <= 0;
            end else if (!sioc_q && sioc && in_frame) begin
                frame_bits <= {frame_bits[26:0], siod};
                bit_count  <= bit_count + 1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    idle_bus_a: assert property (@(posedge clk) disable iff (!reset_n)
        !seen_start |-> !config_done && sioc && siod)
        else report_failure($sformatf("[FAIL] config_done=0x%0h sioc=0x%0h siod=0x%0h",
            $sampled(config_done), $sampled(sioc), $sampled(siod)));
    frame_id_a: assert property (@(posedge clk) disable iff (!reset_n)
        frame_end |-> frame_word[26:19] == camera_cfg_pkg::sensor_write_id)
        else report_failure($sformatf("[FAIL] siod device id: got 0x%02h, expected 0x%02h",
            $sampled(frame_word[26:19]), camera_cfg_pkg::sensor_write_id));
    frame_dc_a: assert property (@(posedge clk) disable iff (!reset_n)
        frame_end |-> {frame_word[18], frame_word[9], frame_word[0]} == 3'b111)
        else report_failure($sformatf("[FAIL] siod don't-care bits: got 0x%0h, expected 0x7",
            $sampled({frame_word[18], frame_word[9], frame_word[0]})));
    frame_write_a: assert property (@(posedge clk) disable iff (!reset_n)
        frame_end && frame_idx < 4 |->
            {frame_word[17:10], frame_word[8:1]} == table_write(frame_idx))
        else report_failure($sformatf("[FAIL] siod reg/data: got 0x%04h, expected 0x%04h",
            $sampled({frame_word[17:10], frame_word[8:1]}), table_write(frame_idx)));
    frame_len_a: assert property (@(posedge clk) disable iff (!reset_n)
        frame_end |-> frame_len == 27)
        else report_failure($sformatf("[FAIL] siod data bits: got 0x%0h, expected 0x1b",
            $sampled(frame_len)));
    frame_count_a: assert property (@(posedge clk) disable iff (!reset_n)
        frame_end |-> frame_idx < 4)
        else report_failure("More than four register writes in one configuration run");
    delay_gap_a: assert property (@(posedge clk) disable iff (!reset_n)
        start_cond && run_frames == 1 |-> gap_cnt >= camera_cfg_pkg::delay_cycles)
        else report_failure($sformatf("[FAIL] gap_cnt: got 0x%0h, expected at least 0x%0h",
            $sampled(gap_cnt), camera_cfg_pkg::delay_cycles));
    done_after_frames_a: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(config_done) |-> run_frames == 4 && !in_frame)
        else report_failure("config_done rose before the fourth frame had stopped");
    done_quiet_a: assert property (@(posedge clk) disable iff (!reset_n)
        start_cond |-> !config_done && !in_frame)
        else report_failure("siod fell with sioc high inside a frame or while done");
    done_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(config_done) |-> $past(config_start))
        else report_failure("config_done fell without a config_start");
    stop_in_frame_a: assert property (@(posedge clk) disable iff (!reset_n)
        stop_cond |-> in_frame)
        else report_failure("siod rose with sioc high outside a frame");

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_cycles) begin
            report_failure("Timeout, the configuration runs did not finish in time");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(41607));
        config_start = 1'b0;
        @(posedge clk);
        while (!reset_n) begin
            @(posedge clk);
        end
        idle_gap();
        pulse_start();
        while (sioc) begin
            @(posedge clk);  // First frame under way
        end
        idle_gap();
        pulse_start();  // Mid-run start, ignored
        while (!config_done) begin
            @(posedge clk);
        end
        idle_gap();
        pulse_start();
        while (config_done) begin
            @(posedge clk);
        end
        while (!config_done) begin
            @(posedge clk);
        end
        idle_gap();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;  // 8 ns period
        end
    end

    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

// ==== source/camera_cfg_top.sv ====
`timescale 1ns/1ps

module camera_cfg_top (
    input  logic clk,
    input  logic reset_n,
    input  logic config_start,
    output logic config_done,
    output logic sioc,
    output logic siod
);

    logic [camera_cfg_pkg::rom_addr_width-1:0] rom_addr;
    camera_cfg_pkg::cfg_word_t                 rom_word;
    logic                                      cmd_valid;
    logic                                      cmd_ready;
    logic [7:0]                                cmd_reg;
    logic [7:0]                                cmd_data;

    //////////////////////////////////////////////////
    // Table -> sequencer -> SCCB master
    //////////////////////////////////////////////////
    camera_cfg_rom camera_cfg_rom_inst (
        .rom_addr (rom_addr),
        .rom_word (rom_word)
    );

    camera_cfg_sequencer camera_cfg_sequencer_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (config_start),
        .rom_addr  (rom_addr),
        .rom_word  (rom_word),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_reg   (cmd_reg),
        .cmd_data  (cmd_data),
        .done      (config_done)
    );

    sccb_master sccb_master_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_reg   (cmd_reg),
        .cmd_data  (cmd_data),
        .sioc      (sioc),
        .siod      (siod)
    );

endmodule

// ==== sccb_master/sccb_master.sv ====
`timescale 1ns/1ps

module sccb_master (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  logic [7:0] cmd_reg,
    input  logic [7:0] cmd_data,
    output logic       sioc,
    output logic       siod
);

    logic [1:0]                                state;
    logic [camera_cfg_pkg::sccb_div_width-1:0] div_cnt;
    logic [1:0]                                quarter;   // Quarter within bit period
    logic [4:0]                                bit_cnt;   // Data bit 0..26
    logic [26:0]                               shift_reg;
    logic                                      quarter_end;
    logic                                      bit_end;
    logic                                      accept;

    assign cmd_ready   = (state == camera_cfg_pkg::sccb_idle);
    assign accept      = cmd_valid && cmd_ready;
    assign quarter_end = (div_cnt == '0);
    assign bit_end     = quarter_end && (quarter == 2'd3);

    //////////////////////////////////////////////////
    // Divider and phase FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= camera_cfg_pkg::sccb_idle;
            div_cnt <= '0;
            quarter <= '0;
            bit_cnt <= '0;
        end else if (state == camera_cfg_pkg::sccb_idle) begin
            if (cmd_valid) begin
                state   <= camera_cfg_pkg::sccb_start;
                div_cnt <= camera_cfg_pkg::sccb_div_last;
                quarter <= '0;
                bit_cnt <= '0;
            end
        end else if (quarter_end) begin
            div_cnt <= camera_cfg_pkg::sccb_div_last;
            quarter <= quarter + 1'b1;  // Wraps to 0 at bit end
            if (bit_end) begin
                case (state)
                    camera_cfg_pkg::sccb_start: begin
                        state <= camera_cfg_pkg::sccb_data;
                    end
                    camera_cfg_pkg::sccb_data: begin
                        if (bit_cnt == 5'd26) begin
                            state <= camera_cfg_pkg::sccb_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: begin
                        state <= camera_cfg_pkg::sccb_idle;  // Stop done
                    end
                endcase
            end
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    // Three 9-bit phases, don't-care bit held high
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= {camera_cfg_pkg::sensor_write_id, 1'b1,
                          cmd_reg, 1'b1,
                          cmd_data, 1'b1};
        end else if ((state == camera_cfg_pkg::sccb_data) && bit_end) begin
            shift_reg <= {shift_reg[25:0], 1'b1};  // MSB first
        end
    end

    //////////////////////////////////////////////////
    // Bus waveform per quarter
    //////////////////////////////////////////////////
    always_comb begin
        sioc = 1'b1;  // Idle bus
        siod = 1'b1;
        case (state)
            camera_cfg_pkg::sccb_start: begin
                // siod falls in quarter 1 with sioc high
                sioc = (quarter != 2'd3);
                siod = (quarter == 2'd0);
            end
            camera_cfg_pkg::sccb_data: begin
                sioc = (quarter == 2'd1) || (quarter == 2'd2);
                siod = shift_reg[26];  // Changes only in quarter 0, sioc low
            end
            camera_cfg_pkg::sccb_stop: begin
                // siod rises in quarter 3 with sioc high
                sioc = (quarter != 2'd0);
                siod = (quarter == 2'd3);
            end
            default: begin
                sioc = 1'b1;
                siod = 1'b1;
            end
        endcase
    end

    // Data must hold over the whole sioc high time
    siod_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
        (sioc && state == camera_cfg_pkg::sccb_data) ##1
        (sioc && state == camera_cfg_pkg::sccb_data) |-> $stable(siod));

endmodule

// ==== source/camera_cfg_sequencer.sv ====
`timescale 1ns/1ps

module camera_cfg_sequencer (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      start,
    output logic [camera_cfg_pkg::rom_addr_width-1:0] rom_addr,
    input  camera_cfg_pkg::cfg_word_t                 rom_word,
    output logic                                      cmd_valid,
    input  logic                                      cmd_ready,
    output logic [7:0]                                cmd_reg,
    output logic [7:0]                                cmd_data,
    output logic                                      done
);

    logic [2:0]  state;
    logic [15:0] delay_cnt;
    logic        take_word;
    logic        is_end;
    logic        is_delay;
    logic        load_cmd;

    // rom_addr is 0 in idle, so a start decodes the first word at once
    assign take_word = (state == camera_cfg_pkg::seq_fetch) ||
                       ((state == camera_cfg_pkg::seq_idle) && start);
    assign is_end    = (rom_word.code == camera_cfg_pkg::end_marker);
    assign is_delay  = (rom_word.code == camera_cfg_pkg::delay_marker);
    assign load_cmd  = take_word && !is_end && !is_delay;

    //////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= camera_cfg_pkg::seq_idle;
            rom_addr  <= '0;
            delay_cnt <= '0;
            cmd_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                camera_cfg_pkg::seq_idle,
                camera_cfg_pkg::seq_fetch: begin
                    if ((state == camera_cfg_pkg::seq_idle) && start) begin
                        done <= 1'b0;  // Cleared by the accepted start
                    end
                    if (take_word) begin
                        if (is_end) begin
                            state <= camera_cfg_pkg::seq_finish;
                        end else if (is_delay) begin
                            // Settling time counts from the end of the last frame
                            if (cmd_ready) begin
                                delay_cnt <= 16'(camera_cfg_pkg::delay_cycles - 1);
                                rom_addr  <= rom_addr + 1'b1;
                                state     <= camera_cfg_pkg::seq_wait;
                            end
                        end else begin
                            cmd_valid <= 1'b1;
                            state     <= camera_cfg_pkg::seq_issue;
                        end
                    end
                end
                camera_cfg_pkg::seq_issue: begin
                    if (cmd_ready) begin  // Write accepted
                        cmd_valid <= 1'b0;
                        rom_addr  <= rom_addr + 1'b1;
                        state     <= camera_cfg_pkg::seq_fetch;
                    end
                end
                camera_cfg_pkg::seq_wait: begin
                    if (delay_cnt == '0) begin
                        state <= camera_cfg_pkg::seq_fetch;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                camera_cfg_pkg::seq_finish: begin
                    // Last frame is out once the master is idle again
                    if (cmd_ready) begin
                        done     <= 1'b1;
                        rom_addr <= '0;
                        state    <= camera_cfg_pkg::seq_idle;
                    end
                end
                default: begin
                    state <= camera_cfg_pkg::seq_idle;
                end
            endcase
        end
    end

    // Write payload, latched from the write view
    always_ff @(posedge clk) begin
        if (load_cmd) begin
            cmd_reg  <= rom_word.wr.reg_addr;
            cmd_data <= rom_word.wr.reg_data;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    cmd_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_reg) && $stable(cmd_data));

    // Master must already be idle with no write pending
    done_rise_a: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(done) |-> !cmd_valid && cmd_ready);

endmodule

// ==== source/camera_cfg_rom.sv ====
`timescale 1ns/1ps

module camera_cfg_rom (
    input  logic [camera_cfg_pkg::rom_addr_width-1:0] rom_addr,
    output camera_cfg_pkg::cfg_word_t                 rom_word
);

    //////////////////////////////////////////////////
    // Register table, read in address order
    //////////////////////////////////////////////////
    always_comb begin
        case (rom_addr)
            8'h00: begin
                rom_word.code = 16'h1280;  // COM7, soft reset
            end
            8'h01: begin
                // Sensor needs settling time after reset
                rom_word.code = camera_cfg_pkg::delay_marker;
            end
            8'h02: begin
                rom_word.code = 16'h1204;  // COM7, RGB output
            end
            8'h03: begin
                rom_word.code = 16'h1101;  // CLKRC, prescaler
            end
            8'h04: begin
                rom_word.code = 16'h40D0;  // COM15, full range RGB565
            end
            8'h05: begin
                rom_word.code = camera_cfg_pkg::end_marker;
            end
            default: begin
                rom_word.code = camera_cfg_pkg::end_marker;  // Past the end
            end
        endcase
    end

endmodule

// ==== common/camera_cfg_pkg.sv ====
package camera_cfg_pkg;

    //////////////////////////////////////////////////
    // Sensor and table constants
    //////////////////////////////////////////////////
    localparam logic [7:0]  sensor_write_id = 8'h42;  // OV7670 write address
    localparam logic [15:0] end_marker      = 16'hFFFF;
    localparam logic [15:0] delay_marker    = 16'hFFF0;
    localparam int unsigned delay_cycles    = 200;    // Stand-in for 10 ms
    localparam int unsigned rom_addr_width  = 8;

    // Bus timing, clocks per quarter of an SCCB bit
    localparam int unsigned sccb_quarter_cycles = 4;
    localparam int unsigned sccb_div_width      = $clog2(sccb_quarter_cycles);
    localparam logic [sccb_div_width-1:0] sccb_div_last =
        sccb_div_width'(sccb_quarter_cycles - 1);

    //////////////////////////////////////////////////
    // FSM encodings
    //////////////////////////////////////////////////
    localparam logic [2:0] seq_idle   = 3'd0;
    localparam logic [2:0] seq_fetch  = 3'd1;
    localparam logic [2:0] seq_issue  = 3'd2;
    localparam logic [2:0] seq_wait   = 3'd3;
    localparam logic [2:0] seq_finish = 3'd4;

    localparam logic [1:0] sccb_idle  = 2'd0;
    localparam logic [1:0] sccb_start = 2'd1;
    localparam logic [1:0] sccb_data  = 2'd2;
    localparam logic [1:0] sccb_stop  = 2'd3;

    // One table word, either a register write or a control marker
    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] reg_data;
    } cfg_write_t;

    typedef union packed {
        cfg_write_t  wr;
        logic [15:0] code;
    } cfg_word_t;

endpackage
